/* tb/wb_trace.txt */
# one row per cycle, all fields hex
# lane 0..2: flags (bit0 valid, bit1 destValid, bit2 exception) mask physDest alIndex result
# branch on lane 1: flags (bit0 isBranch, bit1 conditional, bit2 predTaken,
#   bit3 computedTaken) predTarget computedTarget ckpt
# read tags: tag0 tag1
# expected: completion valids, bypass valids (one bit per lane),
#   branch (bit0 verified, bit1 mispredict), target, readData0, readData1
# read data reflects writes from the rows before the current one
#
# after reset
0 0 00 00 0000  0 0 00 00 0000  0 0 00 00 0000  0 0000 0000 0  00 3f  0 0 0 0000 0000 0000
0 0 00 00 0000  0 0 00 00 0000  0 0 00 00 0000  0 0000 0000 0  01 02  0 0 0 0000 0000 0000
# all three lanes write
3 0 01 00 1111  3 0 02 01 2222  3 0 03 02 3333  0 0000 0000 0  01 02  7 7 0 0000 0000 0000
0 0 00 00 0000  0 0 00 00 0000  0 0 00 00 0000  0 0000 0000 0  01 02  0 0 0 0000 1111 2222
0 0 00 00 0000  0 0 00 00 0000  0 0 00 00 0000  0 0000 0000 0  03 00  0 0 0 0000 3333 0000
# correct taken, then correct not taken
3 2 04 03 4444  1 0 00 04 0000  3 2 05 05 5555  f 0400 0400 1  04 05  7 5 1 0400 0000 0000
3 4 06 06 6666  1 0 00 07 0000  0 0 00 00 0000  3 0800 0800 2  04 05  3 1 1 0000 4444 5555
# direction mispredict on ckpt 0
3 1 07 08 7777  1 0 00 09 0000  3 3 08 0a 8888  b 0000 0a00 0  06 07  2 5 3 0a00 6666 0000
0 0 00 00 0000  0 0 00 00 0000  0 0 00 00 0000  0 0000 0000 0  07 08  0 0 0 0000 0000 0000
# target mispredict on ckpt 3, squashed lane 0 aims at reg 1
3 8 01 0b 9999  1 0 00 0c 0000  3 1 0a 0d aaaa  d 0c00 0c40 3  07 08  6 5 3 0c40 0000 0000
# no destination on lane 0
1 0 0b 0e bbbb  3 0 0c 0f cccc  0 0 00 00 0000  0 0000 0000 0  01 0a  3 2 0 0000 1111 aaaa
0 0 00 00 0000  0 0 00 00 0000  0 0 00 00 0000  0 0000 0000 0  0b 0c  0 0 0 0000 0000 cccc
# branch fields on an empty lane 1
3 1 0d 10 dddd  0 0 00 11 0000  7 0 0e 12 eeee  b 0000 0100 0  0b 01  5 5 0 0000 0000 1111
# not taken mispredict on ckpt 1, lane 0 under another checkpoint
3 4 0f 13 f0f0  1 0 00 14 0000  3 2 10 15 1010  7 0d00 0d00 1  0d 0e  3 5 3 0000 dddd eeee
0 0 00 00 0000  0 0 00 00 0000  0 0 00 00 0000  0 0000 0000 0  0f 10  0 0 0 0000 f0f0 0000
# overwrite regs 2 and 3
3 0 02 16 2a2a  3 0 03 17 3b3b  0 0 00 00 0000  0 0000 0000 0  02 03  3 3 0 0000 2222 3333
0 0 00 00 0000  0 0 00 00 0000  3 0 02 18 4c4c  0 0000 0000 0  02 03  4 4 0 0000 2a2a 3b3b
0 0 00 00 0000  0 0 00 00 0000  0 0 00 00 0000  0 0000 0000 0  02 3f  0 0 0 0000 4c4c 0000
0 0 00 00 0000  0 0 00 00 0000  0 0 00 00 0000  0 0000 0000 0  00 3f  0 0 0 0000 0000 0000

/* files.f */
+incdir+src
src/wbPkg.sv
src/branchResolve.sv
src/writeBack.sv
src/physRegFile.sv
src/wbSubsystem.sv
tb/wbSubsystem_checker.sv
tb/wbSubsystem_tb.sv

/* run.sh */
#!/bin/sh
# build and run the writeback testbench with Verilator
# a failing check ends in $fatal, so the exit status carries the result
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert \
        --top-module wbSubsystem_tb \
        -f files.f \
        -o wbSubsystem_sim
./obj_dir/wbSubsystem_sim

/* tb/wbSubsystem_tb.sv */
`timescale 1ns/1ns
`include "wb_config.svh"

module wbSubsystem_tb
        import wbPkg::*;
();

        localparam int HALF_PERIOD = 50;
        localparam int RESET_CYCLES = 10;
        localparam int IDLE_TIMEOUT = 20;
        localparam int MAX_LINES = 500;
        localparam int TRACE_FIELDS = 27;

        logic clk;
        logic reset;
        exePacket exeLanes [`WB_LANES];
        physTag readTag [`READ_PORTS];
        completion laneCompletion [`WB_LANES];
        bypassPacket laneBypass [`WB_LANES];
        branchOutcome branchResult;
        dataWord readData [`READ_PORTS];

        // fields of the current trace row
        logic [3:0] laneFlags [`WB_LANES];
        logic [3:0] laneMask [`WB_LANES];
        logic [7:0] laneDest [`WB_LANES];
        logic [7:0] laneAl [`WB_LANES];
        logic [31:0] laneResult [`WB_LANES];
        logic [3:0] brFlags;
        logic [31:0] predTarget;
        logic [31:0] compTarget;
        logic [3:0] brCkpt;
        logic [7:0] tag0;
        logic [7:0] tag1;
        logic [3:0] expComplete;
        logic [3:0] expBypass;
        logic [3:0] expBranch;
        logic [31:0] expTarget;
        logic [31:0] expRead0;
        logic [31:0] expRead1;

        wbSubsystem i_wbSubsystem (
                .clk          (clk),
                .reset        (reset),
                .exeLanes_i   (exeLanes),
                .readTag_i    (readTag),
                .completion_o (laneCompletion),
                .bypass_o     (laneBypass),
                .branch_o     (branchResult),
                .readData_o   (readData)
        );

        always #(HALF_PERIOD) clk = ~clk;

        task automatic abortRun(input string reason);
                $display("%s", reason);
                $display("Simulation finished: FAIL");
                $fatal(1, "run stopped");
        endtask

        task automatic checkField(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
                assert (actual === expected)
                else
                begin
                        abortRun($sformatf("FAILED at %0t ns: %s expected %h, actual %h",
                                           $time, name, expected, actual));
                end
        endtask

        function automatic bit anyActive();
                bit active;
                active = branchResult.verified | branchResult.mispredict;
                for (int i = 0; i < `WB_LANES; i++)
                begin
                        active = active | laneCompletion[i].valid | laneBypass[i].valid;
                end
                return active;
        endfunction

        task automatic driveRow();
                for (int i = 0; i < `WB_LANES; i++)
                begin
                        exeLanes[i] = '0;
                        exeLanes[i].valid = laneFlags[i][0];
                        exeLanes[i].destValid = laneFlags[i][1];
                        exeLanes[i].exception = laneFlags[i][2];
                        exeLanes[i].ckptMask = laneMask[i];
                        exeLanes[i].physDest = laneDest[i][5:0];
                        exeLanes[i].alIndex = laneAl[i][4:0];
                        exeLanes[i].result = laneResult[i];
                end
                // branch fields only on the branch lane
                exeLanes[`BRANCH_LANE].branch.isBranch = brFlags[0];
                exeLanes[`BRANCH_LANE].branch.isConditional = brFlags[1];
                exeLanes[`BRANCH_LANE].branch.predTaken = brFlags[2];
                exeLanes[`BRANCH_LANE].branch.computedTaken = brFlags[3];
                exeLanes[`BRANCH_LANE].branch.predTarget = predTarget;
                exeLanes[`BRANCH_LANE].branch.computedTarget = compTarget;
                exeLanes[`BRANCH_LANE].branch.branchCkpt = brCkpt[1:0];
                readTag[0] = tag0[5:0];
                readTag[1] = tag1[5:0];
        endtask

        task automatic checkRow(input int row);
                logic [3:0] actComplete;
                logic [3:0] actBypass;
                logic [3:0] actBranch;
                logic inValid;
                actComplete = '0;
                actBypass = '0;
                for (int i = 0; i < `WB_LANES; i++)
                begin
                        actComplete[i] = laneCompletion[i].valid;
                        actBypass[i] = laneBypass[i].valid;
                end
                actBranch = {2'b00, branchResult.mispredict, branchResult.verified};
                checkField($sformatf("completion_o valid, row %0d", row),
                           {28'd0, expComplete}, {28'd0, actComplete});
                checkField($sformatf("bypass_o valid, row %0d", row),
                           {28'd0, expBypass}, {28'd0, actBypass});
                checkField($sformatf("branch_o mispredict/verified, row %0d", row),
                           {28'd0, expBranch}, {28'd0, actBranch});
                checkField($sformatf("branch_o target, row %0d", row), expTarget,
                           branchResult.target);
                checkField($sformatf("readData_o[0], row %0d", row), expRead0, readData[0]);
                checkField($sformatf("readData_o[1], row %0d", row), expRead1, readData[1]);
                // payload of an invalid input stores as zero
                for (int i = 0; i < `WB_LANES; i++)
                begin
                        inValid = laneFlags[i][0];
                        checkField($sformatf("completion_o[%0d].alIndex, row %0d", i, row),
                                   inValid ? laneAl[i][4:0] : 5'd0, laneCompletion[i].alIndex);
                        checkField($sformatf("completion_o[%0d].exception, row %0d", i, row),
                                   inValid & laneFlags[i][2], laneCompletion[i].exception);
                        checkField($sformatf("bypass_o[%0d].physDest, row %0d", i, row),
                                   inValid ? laneDest[i][5:0] : 6'd0, laneBypass[i].physDest);
                        checkField($sformatf("bypass_o[%0d].result, row %0d", i, row),
                                   inValid ? laneResult[i] : 32'd0, laneBypass[i].result);
                end
                // details of a resolved branch
                if (expBranch[0])
                begin
                        checkField($sformatf("branch_o conditional, row %0d", row), brFlags[1],
                                   branchResult.conditional);
                        checkField($sformatf("branch_o taken, row %0d", row), brFlags[3],
                                   branchResult.taken);
                        checkField($sformatf("branch_o ckpt, row %0d", row), brCkpt[1:0],
                                   branchResult.ckpt);
                end
        endtask

        initial
        begin
                int fd;
                int count;
                int row;
                int lineCount;
                int idleCycles;
                string line;
                bit done;

                clk = 1'b0;
                reset = 1'b1;
                for (int i = 0; i < `WB_LANES; i++)
                begin
                        exeLanes[i] = '0;
                end
                readTag[0] = '0;
                readTag[1] = '0;

                fd = $fopen("tb/wb_trace.txt", "r");
                if (fd == 0)
                begin
                        abortRun("cannot open the trace file tb/wb_trace.txt");
                end

                repeat (RESET_CYCLES) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;

                // registered lanes must come out of reset empty
                idleCycles = 0;
                while (anyActive())
                begin
                        if (idleCycles == IDLE_TIMEOUT)
                        begin
                                abortRun("writeback outputs still active long after reset");
                        end
                        else
                        begin
                                @(posedge clk);
                                idleCycles++;
                        end
                end

                row = 0;
                lineCount = 0;
                done = 1'b0;
                while (!done)
                begin
                        lineCount++;
                        if (lineCount > MAX_LINES)
                        begin
                                abortRun("trace file is longer than the reader allows");
                        end
                        else if ($fgets(line, fd) == 0)
                        begin
                                done = 1'b1;
                        end
                        else if (line.len() > 0 && line.getc(0) != "#")
                        begin
                                count = $sscanf(line,
                                        "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                                        laneFlags[0], laneMask[0], laneDest[0],
                                        laneAl[0], laneResult[0],
                                        laneFlags[1], laneMask[1], laneDest[1],
                                        laneAl[1], laneResult[1],
                                        laneFlags[2], laneMask[2], laneDest[2],
                                        laneAl[2], laneResult[2],
                                        brFlags, predTarget, compTarget, brCkpt, tag0, tag1,
                                        expComplete, expBypass, expBranch, expTarget,
                                        expRead0, expRead1);
                                if (count == TRACE_FIELDS)
                                begin
                                        row++;
                                        @(negedge clk);
                                        driveRow();
                                        // sample just ahead of the next falling edge
                                        @(posedge clk);
                                        #(HALF_PERIOD - 10);
                                        checkRow(row);
                                end
                                else if (count > 0)
                                begin
                                        abortRun($sformatf("trace line %0d has %0d fields, not %0d",
                                                           lineCount, count, TRACE_FIELDS));
                                end
                        end
                end
                $fclose(fd);

                if (row == 0)
                begin
                        abortRun("trace file holds no data rows");
                end
                else
                begin
                        $display("Simulation finished: PASS");
                        $finish;
                end
        end

endmodule

/* tb/wbSubsystem_checker.sv */
`timescale 1ns/1ns
`include "wb_config.svh"

module wbSubsystem_checker
        import wbPkg::*;
(
        input logic         clk,
        input logic         reset,
        input exePacket     lanePkt_i [`WB_LANES],
        input branchOutcome outcome_i,
        input completion    completion_i [`WB_LANES],
        input regWrite      regWrite_i [`WB_LANES]
);

        genvar g;
        generate
                for (g = 0; g < `WB_LANES; g++)
                begin : laneCheck
                        // nothing completes out of an empty lane
                        completeNeedsPacket : assert property (
                                @(posedge clk) disable iff (reset)
                                completion_i[g].valid |-> lanePkt_i[g].valid
                        )
                        else $error("lane %0d completed without a valid packet", g);

                        // wrong path results never reach the active list
                        squashBlocksComplete : assert property (
                                @(posedge clk) disable iff (reset)
                                (outcome_i.verified && outcome_i.mispredict &&
                                 lanePkt_i[g].ckptMask[outcome_i.ckpt])
                                |-> !completion_i[g].valid
                        )
                        else $error("lane %0d completed a squashed packet", g);

                        writeNeedsComplete : assert property (
                                @(posedge clk) disable iff (reset)
                                regWrite_i[g].enable |->
                                (completion_i[g].valid && lanePkt_i[g].destValid)
                        )
                        else $error("lane %0d wrote the register file without completing", g);
                end
        endgenerate

endmodule

bind writeBack wbSubsystem_checker i_wbSubsystemChecker (
        .clk          (clk),
        .reset        (reset),
        .lanePkt_i    (lanePkt),
        .outcome_i    (outcome_i),
        .completion_i (completion_o),
        .regWrite_i   (regWrite_o)
);

/* src/wbSubsystem.sv */
`timescale 1ns/1ns
`include "wb_config.svh"

module wbSubsystem
        import wbPkg::*;
(
        input  logic         clk,
        input  logic         reset,
        input  exePacket     exeLanes_i [`WB_LANES],
        input  physTag       readTag_i [`READ_PORTS],
        output completion    completion_o [`WB_LANES],
        output bypassPacket  bypass_o [`WB_LANES],
        output branchOutcome branch_o,
        output dataWord      readData_o [`READ_PORTS]
);

        // registered branch lane
        branchCheck lane1Branch;

        branchOutcome outcome;

        // surviving writes into the register file
        regWrite laneWrite [`WB_LANES];

        writeBack i_writeBack (
                .clk          (clk),
                .reset        (reset),
                .exeLanes_i   (exeLanes_i),
                .outcome_i    (outcome),
                .branch_o     (lane1Branch),
                .completion_o (completion_o),
                .bypass_o     (bypass_o),
                .regWrite_o   (laneWrite)
        );

        // resolves in the same cycle the packet is registered
        branchResolve i_branchResolve (
                .branch_i  (lane1Branch.info),
                .valid_i   (lane1Branch.valid),
                .outcome_o (outcome)
        );

        physRegFile i_physRegFile (
                .clk        (clk),
                .reset      (reset),
                .regWrite_i (laneWrite),
                .readTag_i  (readTag_i),
                .readData_o (readData_o)
        );

        assign branch_o = outcome;

endmodule

/* src/physRegFile.sv */
`timescale 1ns/1ns
`include "wb_config.svh"

module physRegFile
        import wbPkg::*;
(
        input  logic    clk,
        input  logic    reset,
        input  regWrite regWrite_i [`WB_LANES],
        input  physTag  readTag_i [`READ_PORTS],
        output dataWord readData_o [`READ_PORTS]
);

        dataWord regs [`PHYS_REGS];

        // one write port per lane
        // the lanes never collide, if they did the last lane in the loop wins
        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        for (int r = 0; r < `PHYS_REGS; r++)
                        begin
                                regs[r] <= '0;
                        end
                end
                else
                begin
                        for (int i = 0; i < `WB_LANES; i++)
                        begin
                                if (regWrite_i[i].enable)
                                begin
                                        regs[regWrite_i[i].physDest] <= regWrite_i[i].data;
                                end
                        end
                end
        end

        // reads are combinational, old value during a same-cycle write
        always_comb
        begin
                for (int p = 0; p < `READ_PORTS; p++)
                begin
                        readData_o[p] = regs[readTag_i[p]];
                end
        end

endmodule

/* src/writeBack.sv */
`timescale 1ns/1ns
`include "wb_config.svh"

module writeBack
        import wbPkg::*;
(
        input  logic         clk,
        input  logic         reset,
        input  exePacket     exeLanes_i [`WB_LANES],
        input  branchOutcome outcome_i,
        output branchCheck   branch_o,
        output completion    completion_o [`WB_LANES],
        output bypassPacket  bypass_o [`WB_LANES],
        output regWrite      regWrite_o [`WB_LANES]
);

        // lane packets held for one cycle
        exePacket lanePkt [`WB_LANES];

        // wrong-path squash per lane
        logic [`WB_LANES-1:0] cancel;

        // valid and not squashed
        logic [`WB_LANES-1:0] laneDone;

        // squash target of the branch resolving this cycle
        logic squashActive;
        ckptId squashCkpt;

        // an invalid input stores as all zero, stale fields never survive
        always_ff @(posedge clk)
        begin
                for (int i = 0; i < `WB_LANES; i++)
                begin
                        if (reset || !exeLanes_i[i].valid)
                        begin
                                lanePkt[i] <= '0;
                        end
                        else
                        begin
                                lanePkt[i] <= exeLanes_i[i];
                        end
                end
        end

        // branch lane goes out to the resolver
        always_comb
        begin
                branch_o.valid = lanePkt[`BRANCH_LANE].valid;
                branch_o.info = lanePkt[`BRANCH_LANE].branch;
        end

        assign squashActive = outcome_i.verified & outcome_i.mispredict;
        assign squashCkpt = outcome_i.ckpt;

        // anything depending on the mispredicted checkpoint is dropped,
        // the branch itself included when it sits under its own bit
        always_comb
        begin
                for (int i = 0; i < `WB_LANES; i++)
                begin
                        cancel[i] = squashActive & lanePkt[i].ckptMask[squashCkpt];
                        laneDone[i] = lanePkt[i].valid & ~cancel[i];
                end
        end

        // completion to the active list
        always_comb
        begin
                for (int i = 0; i < `WB_LANES; i++)
                begin
                        completion_o[i].valid = laneDone[i];
                        completion_o[i].alIndex = lanePkt[i].alIndex;
                        completion_o[i].exception = lanePkt[i].exception;
                end
        end

        // bypass ignores the squash, consumers on the wrong path
        // get flushed by their own checkpoint
        always_comb
        begin
                for (int i = 0; i < `WB_LANES; i++)
                begin
                        bypass_o[i].valid = lanePkt[i].valid & lanePkt[i].destValid;
                        bypass_o[i].physDest = lanePkt[i].physDest;
                        bypass_o[i].result = lanePkt[i].result;
                end
        end

        // only surviving results reach the register file
        always_comb
        begin
                for (int i = 0; i < `WB_LANES; i++)
                begin
                        regWrite_o[i].enable = laneDone[i] & lanePkt[i].destValid;
                        regWrite_o[i].physDest = lanePkt[i].physDest;
                        regWrite_o[i].data = lanePkt[i].result;
                end
        end

endmodule

/* src/branchResolve.sv */
`timescale 1ns/1ns
`include "wb_config.svh"

module branchResolve
        import wbPkg::*;
(
        input  branchInfo    branch_i,
        input  logic         valid_i,
        output branchOutcome outcome_o
);

        logic verified;
        logic taken;
        logic dirWrong;
        logic targetWrong;

        // a branch is checked only when the lane holds one
        assign verified = valid_i & branch_i.isBranch;

        assign taken = verified & branch_i.computedTaken;

        // direction only matters for conditional branches
        assign dirWrong = branch_i.isConditional &
                          (branch_i.computedTaken != branch_i.predTaken);

        // a taken branch also has to land on the predicted target
        assign targetWrong = taken &
                             (branch_i.computedTarget != branch_i.predTarget);

        always_comb
        begin
                outcome_o.verified = verified;
                outcome_o.mispredict = verified & (dirWrong | targetWrong);
                outcome_o.conditional = verified & branch_i.isConditional;
                outcome_o.ckpt = branch_i.branchCkpt;
                outcome_o.taken = taken;
                // redirect target, zero when falling through
                if (taken)
                begin
                        outcome_o.target = branch_i.computedTarget;
                end
                else
                begin
                        outcome_o.target = '0;
                end
        end

endmodule

/* src/wbPkg.sv */
`include "wb_config.svh"

package wbPkg;

        typedef logic [`DATA_WIDTH-1:0] dataWord;
        typedef logic [`PC_WIDTH-1:0] pcAddr;
        typedef logic [$clog2(`PHYS_REGS)-1:0] physTag;
        typedef logic [$clog2(`ACTIVE_ENTRIES)-1:0] alTag;
        typedef logic [$clog2(`CHECKPOINTS)-1:0] ckptId;
        typedef logic [`CHECKPOINTS-1:0] ckptMask;

        // prediction and execution result of a control instruction
        typedef struct packed {
                logic isBranch;
                logic isConditional;
                logic predTaken;
                pcAddr predTarget;
                logic computedTaken;
                pcAddr computedTarget;
                ckptId branchCkpt;
        } branchInfo;

        // one lane's execution result
        typedef struct packed {
                logic valid;
                ckptMask ckptMask;
                logic destValid;
                physTag physDest;
                alTag alIndex;
                dataWord result;
                logic exception;
                branchInfo branch;
        } exePacket;

        // registered branch lane, handed to the resolver
        typedef struct packed {
                logic valid;
                branchInfo info;
        } branchCheck;

        typedef struct packed {
                logic verified;
                logic mispredict;
                logic conditional;
                ckptId ckpt;
                logic taken;
                pcAddr target;
        } branchOutcome;

        // report to the active list
        typedef struct packed {
                logic valid;
                alTag alIndex;
                logic exception;
        } completion;

        typedef struct packed {
                logic valid;
                physTag physDest;
                dataWord result;
        } bypassPacket;

        typedef struct packed {
                logic enable;
                physTag physDest;
                dataWord data;
        } regWrite;

endpackage

/* src/wb_config.svh */
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// datapath widths
`define DATA_WIDTH 32
`define PC_WIDTH 32

// physical register file size, sets the tag width
`define PHYS_REGS 64

// active list depth, sets the completion index width
`define ACTIVE_ENTRIES 32

// branch checkpoints, one mask bit each
`define CHECKPOINTS 4

// result lanes into writeback
// lane 0 simple alu, lane 1 branch/alu, lane 2 load/store
`define WB_LANES 3

// lane that carries branch results
`define BRANCH_LANE 1

// external register file read ports
`define READ_PORTS 2

`endif
